//--- common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and register file
`define CPU_REG_BIT     16
`define CPU_NUM_REG     16

// Instruction fields
`define CPU_IMM_BIT     8
`define CPU_OP_BIT      3

// Fetch sequencing
`define CPU_PC_BIT      8
`define CPU_ID_BIT      8

// Latency from issue to writeback in the multiplier
`define CPU_MUL_STAGES  2

`endif

//--- common/cpu_isa_pkg.sv
`include "cpu_cfg.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_REG_BIT-1:0]          data_t;
    typedef logic [$clog2(`CPU_NUM_REG)-1:0]  reg_id_t;
    typedef logic [`CPU_IMM_BIT-1:0]          imm_t;
    typedef logic [`CPU_PC_BIT-1:0]           pc_t;
    typedef logic [`CPU_ID_BIT-1:0]           inst_id_t;
    typedef logic [`CPU_OP_BIT-1:0]           op_t;

    // Opcode 7 was the branch and is no longer legal
    localparam op_t OP_ST      = 3'd0;
    localparam op_t OP_CMP_GT  = 3'd1;
    localparam op_t OP_ADD_IMM = 3'd2;
    localparam op_t OP_ADD     = 3'd3;
    localparam op_t OP_SHL     = 3'd4;
    localparam op_t OP_SHR     = 3'd5;
    localparam op_t OP_MUL     = 3'd6;

endpackage

//--- common/cpu_uarch_pkg.sv
`include "cpu_cfg.svh"

package cpu_uarch_pkg;

    // One bit per architectural register, set while a write is in flight
    typedef logic [`CPU_NUM_REG-1:0] reg_mask_t;

    typedef enum logic {
        FETCH_RUN,
        FETCH_DONE
    } fetch_state_t;

endpackage

//--- common/issue_if.sv
`timescale 1ns/1ps

interface issue_if;
    import cpu_isa_pkg::*;

    // At most one of the two strobes is high in a cycle
    logic     int_vld;
    logic     mul_vld;
    op_t      op;
    inst_id_t id;
    reg_id_t  dst;
    imm_t     imm;

    // Operands as read from the register file in the issue cycle
    data_t    a;
    data_t    b;

    modport ctrl (
        output int_vld, mul_vld, op, id, dst, imm, a, b
    );

    modport unit (
        input  int_vld, mul_vld, op, id, dst, imm, a, b
    );

endinterface

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_isa_pkg::reg_id_t  rd_addr0,
    input  cpu_isa_pkg::reg_id_t  rd_addr1,
    output cpu_isa_pkg::data_t    rd_data0,
    output cpu_isa_pkg::data_t    rd_data1,
    input  logic                  alu_wb_vld,
    input  cpu_isa_pkg::reg_id_t  alu_wb_reg,
    input  cpu_isa_pkg::data_t    alu_wb_data,
    input  logic                  mul_wb_vld,
    input  cpu_isa_pkg::reg_id_t  mul_wb_reg,
    input  cpu_isa_pkg::data_t    mul_wb_data
);
    import cpu_isa_pkg::*;

    data_t regs [`CPU_NUM_REG];

    // No bypass: the scoreboard holds readers until the cycle after writeback
    assign rd_data0 = regs[rd_addr0];
    assign rd_data1 = regs[rd_addr1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alu_wb_vld) begin
                regs[alu_wb_reg] <= alu_wb_data;
            end
            if (mul_wb_vld) begin
                regs[mul_wb_reg] <= mul_wb_data;
            end
        end
    end

    a_no_write_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_wb_vld && mul_wb_vld && alu_wb_reg == mul_wb_reg));

endmodule

//--- hw/exec/int_unit.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module int_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    issue_if.unit                  issue,
    output logic                   alu_wb_vld,
    output cpu_isa_pkg::reg_id_t   alu_wb_reg,
    output cpu_isa_pkg::data_t     alu_wb_data,
    output logic                   write_mem_vld,
    output cpu_isa_pkg::inst_id_t  write_mem_id,
    output cpu_isa_pkg::data_t     write_mem_addr,
    output cpu_isa_pkg::data_t     write_mem_data
);
    import cpu_isa_pkg::*;

    localparam int SHAMT_BIT = $clog2(`CPU_REG_BIT);

    logic [SHAMT_BIT-1:0] shamt;
    data_t                result;

    assign shamt = issue.b[SHAMT_BIT-1:0];

    always_comb begin
        case (issue.op)
            OP_CMP_GT:  result = (issue.a > issue.b) ? data_t'(1) : '0;
            OP_ADD_IMM: result = issue.a + data_t'(issue.imm);
            OP_ADD:     result = issue.a + issue.b;
            OP_SHL:     result = issue.a << shamt;
            OP_SHR:     result = issue.a >> shamt;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_wb_vld    <= 1'b0;
            write_mem_vld <= 1'b0;
        end else begin
            alu_wb_vld    <= issue.int_vld && (issue.op != OP_ST);
            write_mem_vld <= issue.int_vld && (issue.op == OP_ST);
        end
    end

    // Store address comes from src0 and store data from src1
    always_ff @(posedge clk) begin
        if (issue.int_vld) begin
            alu_wb_reg     <= issue.dst;
            alu_wb_data    <= result;
            write_mem_id   <= issue.id;
            write_mem_addr <= issue.a;
            write_mem_data <= issue.b;
        end
    end

    // There is no multiplier here, so a multiply routed to this unit would write back zero
    a_no_mul_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue.int_vld |-> (issue.op != OP_MUL && !issue.mul_vld));

endmodule

//--- hw/exec/mul_unit.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module mul_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    issue_if.unit                 issue,
    output logic                  mul_wb_vld,
    output cpu_isa_pkg::reg_id_t  mul_wb_reg,
    output cpu_isa_pkg::data_t    mul_wb_data
);
    import cpu_isa_pkg::*;

    localparam int STAGES = `CPU_MUL_STAGES;

    logic              s1_vld;
    reg_id_t           s1_dst;
    data_t             s1_a;
    data_t             s1_b;
    data_t             product;
    logic [STAGES-2:0] vld_q;
    reg_id_t           dst_q  [STAGES-1];
    data_t             prod_q [STAGES-1];

    // Only the low half of the product is architecturally visible
    assign product = s1_a * s1_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            vld_q  <= '0;
        end else begin
            s1_vld   <= issue.mul_vld;
            vld_q[0] <= s1_vld;
            for (int i = 1; i < STAGES - 1; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue.mul_vld) begin
            s1_dst <= issue.dst;
            s1_a   <= issue.a;
            s1_b   <= issue.b;
        end
        dst_q[0]  <= s1_dst;
        prod_q[0] <= product;
        for (int i = 1; i < STAGES - 1; i++) begin
            dst_q[i]  <= dst_q[i-1];
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign mul_wb_vld  = vld_q[STAGES-2];
    assign mul_wb_reg  = dst_q[STAGES-2];
    assign mul_wb_data = prod_q[STAGES-2];

endmodule

//--- hw/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_vld,
    input  logic                   inst_last,
    input  cpu_isa_pkg::op_t       inst_op,
    input  cpu_isa_pkg::inst_id_t  inst_id,
    input  cpu_isa_pkg::reg_id_t   inst_dst_reg,
    input  cpu_isa_pkg::reg_id_t   inst_src_reg0,
    input  cpu_isa_pkg::reg_id_t   inst_src_reg1,
    input  cpu_isa_pkg::imm_t      inst_imm,
    output logic                   inst_rdy,
    output logic                   fetch_vld,
    output cpu_isa_pkg::pc_t       fetch_pc,
    output cpu_isa_pkg::inst_id_t  fetch_id,
    output cpu_isa_pkg::reg_id_t   rd_addr0,
    output cpu_isa_pkg::reg_id_t   rd_addr1,
    input  cpu_isa_pkg::data_t     rd_data0,
    input  cpu_isa_pkg::data_t     rd_data1,
    input  logic                   alu_wb_vld,
    input  cpu_isa_pkg::reg_id_t   alu_wb_reg,
    input  logic                   mul_wb_vld,
    input  cpu_isa_pkg::reg_id_t   mul_wb_reg,
    output logic                   exec_finish,
    issue_if.ctrl                  issue
);
    import cpu_isa_pkg::*;
    import cpu_uarch_pkg::*;

    fetch_state_t state;
    pc_t          pc_q;
    inst_id_t     id_q;
    reg_mask_t    pending;
    reg_mask_t    set_mask;
    reg_mask_t    clr_mask;
    logic         is_store;
    logic         hazard;
    logic         accept;

    // Stores write no register, so only their sources are checked
    assign is_store = (inst_op == OP_ST);
    assign hazard   = pending[inst_src_reg0] || pending[inst_src_reg1] ||
                      (!is_store && pending[inst_dst_reg]);
    assign inst_rdy = inst_vld && !hazard;
    assign accept   = inst_vld && inst_rdy;

    // The environment answers a fetch in the next cycle, so an idle
    // instruction port means nothing is outstanding
    assign fetch_vld = (state == FETCH_RUN) && (!inst_vld || (accept && !inst_last));
    assign fetch_pc  = pc_q;
    assign fetch_id  = id_q;

    assign rd_addr0 = inst_src_reg0;
    assign rd_addr1 = inst_src_reg1;

    assign issue.int_vld = accept && (inst_op != OP_MUL);
    assign issue.mul_vld = accept && (inst_op == OP_MUL);
    assign issue.op      = inst_op;
    assign issue.id      = inst_id;
    assign issue.dst     = inst_dst_reg;
    assign issue.imm     = inst_imm;
    assign issue.a       = rd_data0;
    assign issue.b       = rd_data1;

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (accept && !is_store) begin
            set_mask[inst_dst_reg] = 1'b1;
        end
        if (alu_wb_vld) begin
            clr_mask[alu_wb_reg] = 1'b1;
        end
        if (mul_wb_vld) begin
            clr_mask[mul_wb_reg] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
            id_q <= '0;
        end else if (fetch_vld) begin
            pc_q <= pc_q + 1'b1;
            id_q <= id_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FETCH_RUN;
            pending     <= '0;
            exec_finish <= 1'b0;
        end else begin
            if (state == FETCH_RUN && accept && inst_last) begin
                state <= FETCH_DONE;
            end
            // A new issue wins over a writeback to the same register
            pending <= (pending & ~clr_mask) | set_mask;
            if (state == FETCH_DONE && pending == '0) begin
                exec_finish <= 1'b1;
            end
        end
    end

    a_legal_op: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> inst_op <= OP_MUL);

    // Writebacks come from the execution units and must match a scoreboard entry
    a_alu_wb_pending: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb_vld |-> pending[alu_wb_reg]);
    a_mul_wb_pending: assert property (@(posedge clk) disable iff (!rst_n)
        mul_wb_vld |-> pending[mul_wb_reg]);

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_vld,
    input  logic                   inst_last,
    input  cpu_isa_pkg::op_t       inst_op,
    input  cpu_isa_pkg::inst_id_t  inst_id,
    input  cpu_isa_pkg::reg_id_t   inst_dst_reg,
    input  cpu_isa_pkg::reg_id_t   inst_src_reg0,
    input  cpu_isa_pkg::reg_id_t   inst_src_reg1,
    input  cpu_isa_pkg::imm_t      inst_imm,
    output logic                   fetch_vld,
    output cpu_isa_pkg::pc_t       fetch_pc,
    output cpu_isa_pkg::inst_id_t  fetch_id,
    output logic                   inst_rdy,
    output logic                   write_mem_vld,
    output cpu_isa_pkg::inst_id_t  write_mem_id,
    output cpu_isa_pkg::data_t     write_mem_addr,
    output cpu_isa_pkg::data_t     write_mem_data,
    output logic                   exec_finish
);
    import cpu_isa_pkg::*;

    reg_id_t rd_addr0;
    reg_id_t rd_addr1;
    data_t   rd_data0;
    data_t   rd_data1;

    logic    alu_wb_vld;
    reg_id_t alu_wb_reg;
    data_t   alu_wb_data;
    logic    mul_wb_vld;
    reg_id_t mul_wb_reg;
    data_t   mul_wb_data;

    issue_if u_issue ();

    issue_ctrl u_issue_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_vld      (inst_vld),
        .inst_last     (inst_last),
        .inst_op       (inst_op),
        .inst_id       (inst_id),
        .inst_dst_reg  (inst_dst_reg),
        .inst_src_reg0 (inst_src_reg0),
        .inst_src_reg1 (inst_src_reg1),
        .inst_imm      (inst_imm),
        .inst_rdy      (inst_rdy),
        .fetch_vld     (fetch_vld),
        .fetch_pc      (fetch_pc),
        .fetch_id      (fetch_id),
        .rd_addr0      (rd_addr0),
        .rd_addr1      (rd_addr1),
        .rd_data0      (rd_data0),
        .rd_data1      (rd_data1),
        .alu_wb_vld    (alu_wb_vld),
        .alu_wb_reg    (alu_wb_reg),
        .mul_wb_vld    (mul_wb_vld),
        .mul_wb_reg    (mul_wb_reg),
        .exec_finish   (exec_finish),
        .issue         (u_issue.ctrl)
    );

    reg_file u_reg_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_addr0    (rd_addr0),
        .rd_addr1    (rd_addr1),
        .rd_data0    (rd_data0),
        .rd_data1    (rd_data1),
        .alu_wb_vld  (alu_wb_vld),
        .alu_wb_reg  (alu_wb_reg),
        .alu_wb_data (alu_wb_data),
        .mul_wb_vld  (mul_wb_vld),
        .mul_wb_reg  (mul_wb_reg),
        .mul_wb_data (mul_wb_data)
    );

    int_unit u_int_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue          (u_issue.unit),
        .alu_wb_vld     (alu_wb_vld),
        .alu_wb_reg     (alu_wb_reg),
        .alu_wb_data    (alu_wb_data),
        .write_mem_vld  (write_mem_vld),
        .write_mem_id   (write_mem_id),
        .write_mem_addr (write_mem_addr),
        .write_mem_data (write_mem_data)
    );

    mul_unit u_mul_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (u_issue.unit),
        .mul_wb_vld  (mul_wb_vld),
        .mul_wb_reg  (mul_wb_reg),
        .mul_wb_data (mul_wb_data)
    );

endmodule

//--- bench/cpu_tb_ref.svh
`ifndef CPU_TB_REF_SVH
`define CPU_TB_REF_SVH

int unsigned rng_state = 32;

// Upper bits are returned because the low bits of an LCG cycle quickly
function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> 8;
endfunction

function automatic void add_inst(input op_t op, input reg_id_t dst, input reg_id_t s0,
                                 input reg_id_t s1, input imm_t imm);
    prog_op[prog_len]  = op;
    prog_dst[prog_len] = dst;
    prog_s0[prog_len]  = s0;
    prog_s1[prog_len]  = s1;
    prog_imm[prog_len] = imm;
    prog_len++;
endfunction

// Each register is stored with itself as address and data
function automatic void add_final_stores();
    for (int r = 0; r < 16; r++) begin
        add_inst(OP_ST, 4'd0, reg_id_t'(r), reg_id_t'(r), 8'd0);
    end
endfunction

function automatic void gen_random(input int n);
    int unsigned op_draw;
    int unsigned fld_draw;
    for (int k = 0; k < n; k++) begin
        op_draw  = lcg_next();
        fld_draw = lcg_next();
        add_inst(op_t'(op_draw % 7), reg_id_t'(fld_draw), reg_id_t'(fld_draw >> 4),
                 reg_id_t'(fld_draw >> 8), imm_t'(fld_draw >> 12));
    end
endfunction

// Runs the program in order on zeroed registers and queues every store it makes
function automatic void run_reference();
    data_t regs [16];
    data_t a;
    data_t b;
    for (int r = 0; r < 16; r++) begin
        regs[r] = '0;
    end
    exp_id.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < prog_len; i++) begin
        a = regs[prog_s0[i]];
        b = regs[prog_s1[i]];
        case (prog_op[i])
            OP_ST: begin
                exp_id.push_back(inst_id_t'(i));
                exp_addr.push_back(a);
                exp_data.push_back(b);
            end
            OP_CMP_GT:  regs[prog_dst[i]] = (a > b) ? 16'd1 : 16'd0;
            OP_ADD_IMM: regs[prog_dst[i]] = a + {8'd0, prog_imm[i]};
            OP_ADD:     regs[prog_dst[i]] = a + b;
            OP_SHL:     regs[prog_dst[i]] = a << b[3:0];
            OP_SHR:     regs[prog_dst[i]] = a >> b[3:0];
            default:    regs[prog_dst[i]] = a * b;
        endcase
    end
endfunction

`endif

//--- bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_isa_pkg::*;

    localparam int DIR_LEN     = 25;
    localparam int MUL_LEN     = 28;
    localparam int RND_LEN     = 216;
    localparam int CYCLE_LIMIT = 8 * (DIR_LEN + MUL_LEN + RND_LEN) + 100;

    logic     clk;
    logic     rst_n;
    logic     inst_vld;
    logic     inst_last;
    op_t      inst_op;
    inst_id_t inst_id;
    reg_id_t  inst_dst_reg;
    reg_id_t  inst_src_reg0;
    reg_id_t  inst_src_reg1;
    imm_t     inst_imm;
    logic     fetch_vld;
    pc_t      fetch_pc;
    inst_id_t fetch_id;
    logic     inst_rdy;
    logic     write_mem_vld;
    inst_id_t write_mem_id;
    data_t    write_mem_addr;
    data_t    write_mem_data;
    logic     exec_finish;

    op_t      prog_op  [256];
    reg_id_t  prog_dst [256];
    reg_id_t  prog_s0  [256];
    reg_id_t  prog_s1  [256];
    imm_t     prog_imm [256];
    int       prog_len;
    inst_id_t exp_id   [$];
    data_t    exp_addr [$];
    data_t    exp_data [$];
    int       exp_total;
    int       writes_seen;
    int       fetch_cnt;
    int       errors;
    int       cycles;
    int       tests_run;
    int       tests_failed;
    logic     last_acc;
    logic     finish_seen;

    `include "cpu_tb_ref.svh"

    cpu_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_vld       (inst_vld),
        .inst_last      (inst_last),
        .inst_op        (inst_op),
        .inst_id        (inst_id),
        .inst_dst_reg   (inst_dst_reg),
        .inst_src_reg0  (inst_src_reg0),
        .inst_src_reg1  (inst_src_reg1),
        .inst_imm       (inst_imm),
        .fetch_vld      (fetch_vld),
        .fetch_pc       (fetch_pc),
        .fetch_id       (fetch_id),
        .inst_rdy       (inst_rdy),
        .write_mem_vld  (write_mem_vld),
        .write_mem_id   (write_mem_id),
        .write_mem_addr (write_mem_addr),
        .write_mem_data (write_mem_data),
        .exec_finish    (exec_finish)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Instruction memory: answers each fetch from the next falling edge until accepted
    always begin : responder
        logic     acc;
        logic     fv;
        pc_t      fpc;
        inst_id_t fid;
        @(posedge clk);
        acc = rst_n && inst_vld && inst_rdy;
        fv  = rst_n && fetch_vld;
        fpc = fetch_pc;
        fid = fetch_id;
        if (fv) begin
            check("fetch_pc", fpc, fetch_cnt);
            check("fetch_id", fid, fetch_cnt);
            if (last_acc || (acc && inst_last)) begin
                $display("ERROR at %0t: fetch issued after the last instruction", $time);
                errors++;
            end
            fetch_cnt++;
        end
        if (acc && inst_last) begin
            last_acc = 1'b1;
        end
        @(negedge clk);
        if (acc) begin
            inst_vld  = 1'b0;
            inst_last = 1'b0;
        end
        if (fv && rst_n && int'(fpc) < prog_len) begin
            inst_vld      = 1'b1;
            inst_op       = prog_op[fpc];
            inst_dst_reg  = prog_dst[fpc];
            inst_src_reg0 = prog_s0[fpc];
            inst_src_reg1 = prog_s1[fpc];
            inst_imm      = prog_imm[fpc];
            inst_id       = fid;
            inst_last     = (int'(fpc) == prog_len - 1);
        end else if (fv && rst_n) begin
            $display("ERROR at %0t: fetch beyond the end of the program", $time);
            errors++;
        end
    end

    // Write first, then finish, so a write in the finish cycle is counted
    always @(posedge clk) begin : monitor
        if (rst_n && write_mem_vld) begin
            if (exp_id.size() == 0) begin
                $display("ERROR at %0t: memory write when none was expected", $time);
                errors++;
            end else begin
                check("write_mem_id", write_mem_id, exp_id.pop_front());
                check("write_mem_addr", write_mem_addr, exp_addr.pop_front());
                check("write_mem_data", write_mem_data, exp_data.pop_front());
                writes_seen++;
            end
        end
        if (rst_n && finish_seen && !exec_finish) begin
            $display("ERROR at %0t: exec_finish dropped before reset", $time);
            errors++;
        end
        if (rst_n && exec_finish && !finish_seen) begin
            finish_seen = 1'b1;
            check("writes at exec_finish", writes_seen, exp_total);
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: run timed out after %0d cycles", cycles);
        $display("Testbench failed");
        $finish;
    end

    task automatic apply_reset();
        @(negedge clk);
        rst_n       = 1'b0;
        inst_vld    = 1'b0;
        inst_last   = 1'b0;
        fetch_cnt   = 0;
        writes_seen = 0;
        last_acc    = 1'b0;
        finish_seen = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check("write_mem_vld", write_mem_vld, 0);
        check("exec_finish", exec_finish, 0);
        check("inst_rdy", inst_rdy, 0);
        check("fetch_vld", fetch_vld, 1);
    endtask

    task automatic run_program(input string name);
        int start_errors;
        start_errors = errors;
        run_reference();
        exp_total = exp_id.size();
        apply_reset();
        while (!finish_seen) begin
            @(negedge clk);
        end
        // Quiet period in which any stray write would reach the monitor
        repeat (10) @(negedge clk);
        check("writes left", exp_id.size(), 0);
        check("fetch count", fetch_cnt, prog_len);
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("test %-8s %0d instructions, %0d writes, %0d errors", name, prog_len,
                 writes_seen, errors - start_errors);
    endtask

    initial begin
        rst_n = 1'b0;
        inst_vld = 1'b0;
        inst_last = 1'b0;
        inst_op = '0;
        inst_id = '0;
        inst_dst_reg = '0;
        inst_src_reg0 = '0;
        inst_src_reg1 = '0;
        inst_imm = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        last_acc = 1'b0;
        finish_seen = 1'b0;

        prog_len = 0;
        add_inst(OP_ADD_IMM, 4'd1, 4'd0, 4'd0, 8'hc8);
        add_inst(OP_ADD_IMM, 4'd2, 4'd0, 4'd0, 8'h03);
        add_inst(OP_ADD, 4'd3, 4'd1, 4'd2, 8'h00);
        add_inst(OP_SHL, 4'd4, 4'd1, 4'd2, 8'h00);
        add_inst(OP_SHR, 4'd5, 4'd3, 4'd2, 8'h00);
        add_inst(OP_CMP_GT, 4'd6, 4'd1, 4'd2, 8'h00);
        add_inst(OP_CMP_GT, 4'd7, 4'd2, 4'd1, 8'h00);
        add_inst(OP_ADD_IMM, 4'd8, 4'd4, 4'd0, 8'hff);
        add_inst(OP_ST, 4'd0, 4'd1, 4'd3, 8'h00);
        add_final_stores();
        run_program("int_ops");

        // Dependent chain first, then independent multiplies issued back to back
        prog_len = 0;
        add_inst(OP_ADD_IMM, 4'd1, 4'd0, 4'd0, 8'd7);
        add_inst(OP_ADD_IMM, 4'd2, 4'd0, 4'd0, 8'd13);
        add_inst(OP_MUL, 4'd3, 4'd1, 4'd2, 8'd0);
        add_inst(OP_MUL, 4'd4, 4'd3, 4'd3, 8'd0);
        add_inst(OP_ADD, 4'd5, 4'd4, 4'd1, 8'd0);
        add_inst(OP_MUL, 4'd6, 4'd5, 4'd2, 8'd0);
        add_inst(OP_MUL, 4'd6, 4'd6, 4'd6, 8'd0);
        add_inst(OP_MUL, 4'd7, 4'd1, 4'd2, 8'd0);
        add_inst(OP_MUL, 4'd8, 4'd2, 4'd2, 8'd0);
        add_inst(OP_MUL, 4'd9, 4'd1, 4'd1, 8'd0);
        add_inst(OP_MUL, 4'd10, 4'd2, 4'd1, 8'd0);
        add_inst(OP_MUL, 4'd11, 4'd5, 4'd1, 8'd0);
        add_final_stores();
        run_program("mul_chain");

        prog_len = 0;
        gen_random(200);
        add_final_stores();
        run_program("random");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- cpu.f
+incdir+common
+incdir+bench
common/cpu_isa_pkg.sv
common/cpu_uarch_pkg.sv
common/issue_if.sv
hw/reg_file.sv
hw/exec/int_unit.sv
hw/exec/mul_unit.sv
hw/issue_ctrl.sv
hw/cpu_top.sv
bench/cpu_tb.sv
